/* project.f */
rtl/mem_pkg.sv
rtl/mem_bus_if.sv
rtl/lsu_align.sv
rtl/data_ram.sv
rtl/mem_cfg_regs.sv
rtl/mem_stage_top.sv
tests/tb_mem_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mem_stage
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_mem_stage.sv */
module tb_mem_stage import mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_BYTES = 4096;
	localparam int N_WORDS = 64;
	localparam int N_LANE_WORDS = 8;
	localparam int N_GUARD = 40;
	localparam int TEST_CYCLES = 8 + 12 + 3 * N_WORDS + 30 * N_LANE_WORDS + 40 +
		3 * N_GUARD + 30;

	logic      clk;
	logic      rst_n_i;
	logic      req_i;
	mem_op_e   op_i;
	word_t     addr_i;
	word_t     wdata_i;
	word_t     load_data_o;
	logic      misalign_o;
	logic      fault_o;
	logic      cfg_we_i;
	cfg_addr_e cfg_addr_i;
	word_t     cfg_wdata_i;
	word_t     cfg_rdata_o;

	// Shadow memory and configuration model.
	logic [7:0]             shadow [MEM_BYTES];
	logic                   m_guard = 1'b0;
	word_t                  m_limit = '0;
	logic [FAULT_CNT_W-1:0] m_cnt = '0;
	logic [31:0]            seed = 32'd35166;

	mem_stage_top #(
		.ADDR_WORDS(1024)
	) u_dut (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.req_i      (req_i),
		.op_i       (op_i),
		.addr_i     (addr_i),
		.wdata_i    (wdata_i),
		.load_data_o(load_data_o),
		.misalign_o (misalign_o),
		.fault_o    (fault_o),
		.cfg_we_i   (cfg_we_i),
		.cfg_addr_i (cfg_addr_i),
		.cfg_wdata_i(cfg_wdata_i),
		.cfg_rdata_o(cfg_rdata_o)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ####################
	// Helpers.
	// ####################

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic get_rand(output word_t r);
		logic [15:0] hi;
		seed = lcg_next(seed);
		hi = seed[31:16];
		seed = lcg_next(seed);
		r = {hi, seed[31:16]};
	endtask

	// Expected load word and flags from the shadow bytes.
	function automatic word_t ref_load(input mem_op_e op, input word_t addr,
		input logic [7:0] mem [MEM_BYTES], input logic g_en, input word_t limit,
		output logic mis, output logic flt);
		int          a;
		logic [7:0]  b;
		logic [15:0] h;
		logic        st;
		a = int'(addr[11:0]);
		b = mem[a];
		h = {mem[(a + 1) % MEM_BYTES], mem[a]};
		st = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
		mis = ((op == OP_LH || op == OP_LHU || op == OP_SH) && addr[0]) ||
			((op == OP_LW || op == OP_SW) && addr[1:0] != 2'b00);
		flt = st && !mis && g_en && (addr < limit);
		if (mis || st) begin
			return '0;
		end
		case (op)
			OP_LB:   return {{24{b[7]}}, b};
			OP_LBU:  return {24'b0, b};
			OP_LH:   return {{16{h[15]}}, h};
			OP_LHU:  return {16'b0, h};
			default: return {mem[a + 3], mem[a + 2], h};
		endcase
	endfunction

	task automatic check_word(input string name, input word_t act, input word_t exp);
		if (act !== exp) begin
			$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
			$display("Checks failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_flag(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
			$display("Checks failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_count(input string name, input logic [FAULT_CNT_W-1:0] act,
		input logic [FAULT_CNT_W-1:0] exp);
		if (act !== exp) begin
			$display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
			$display("Checks failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic drive_cycle(input logic req, input mem_op_e op, input word_t addr,
		input word_t data, input logic we, input cfg_addr_e caddr, input word_t cdata);
		@(posedge clk);
		#1;
		req_i       = req;
		op_i        = op;
		addr_i      = addr;
		wdata_i     = data;
		cfg_we_i    = we;
		cfg_addr_i  = caddr;
		cfg_wdata_i = cdata;
	endtask

	task automatic access_mem(input mem_op_e op, input word_t addr, input word_t data);
		drive_cycle(1'b1, op, addr, data, 1'b0, cfg_addr_i, '0);
	endtask

	task automatic write_cfg(input cfg_addr_e caddr, input word_t cdata);
		drive_cycle(1'b0, OP_LW, '0, '0, 1'b1, caddr, cdata);
	endtask

	task automatic read_cfg(input cfg_addr_e caddr);
		drive_cycle(1'b0, OP_LW, '0, '0, 1'b0, caddr, '0);
	endtask

	// ####################
	// Compare process.
	// ####################

	always begin : compare_outputs
		word_t exp_data;
		word_t exp_cfg;
		logic  exp_mis;
		logic  exp_flt;
		int    a;
		@(posedge clk);
		#7;
		if (rst_n_i) begin
			exp_mis = 1'b0;
			exp_flt = 1'b0;
			exp_data = '0;
			if (req_i) begin
				exp_data = ref_load(op_i, addr_i, shadow, m_guard, m_limit, exp_mis, exp_flt);
			end
			check_word("load_data_o", load_data_o, exp_data);
			check_flag("misalign_o", misalign_o, exp_mis);
			check_flag("fault_o", fault_o, exp_flt);
			case (cfg_addr_i)
				CFG_GUARD_EN: exp_cfg = {31'b0, m_guard};
				CFG_WP_LIMIT: exp_cfg = m_limit;
				default:      exp_cfg = word_t'(m_cnt);
			endcase
			if (cfg_addr_i == CFG_FAULT_CNT) begin
				check_count("fault count", cfg_rdata_o[FAULT_CNT_W-1:0], m_cnt);
			end
			check_word("cfg_rdata_o", cfg_rdata_o, exp_cfg);
			// Model follows the DUT at the coming edge.
			a = int'(addr_i[11:0]);
			if (req_i && !exp_mis && !exp_flt) begin
				case (op_i)
					OP_SB: shadow[a] = wdata_i[7:0];
					OP_SH: begin
						shadow[a]     = wdata_i[7:0];
						shadow[a + 1] = wdata_i[15:8];
					end
					OP_SW: begin
						for (int k = 0; k < 4; k++) begin
							shadow[a + k] = wdata_i[8*k +: 8];
						end
					end
					default: ;
				endcase
			end
			if (exp_flt && m_cnt != '1) begin
				m_cnt = m_cnt + 1'b1;
			end
			if (cfg_we_i) begin
				case (cfg_addr_i)
					CFG_GUARD_EN:  m_guard = cfg_wdata_i[0];
					CFG_WP_LIMIT:  m_limit = cfg_wdata_i;
					CFG_FAULT_CNT: m_cnt = '0;
					default: ;
				endcase
			end
		end
	end

	initial begin : watchdog
		#((TEST_CYCLES + 100) * 8);
		$display("Timeout: the tests did not finish within the expected time");
		$display("Checks failed");
		$fatal(1, "Watchdog expired");
	end

	// ####################
	// Stimulus.
	// ####################

	initial begin
		word_t   r;
		word_t   base;
		word_t   addr_q[$];
		mem_op_e mis_ops[5];
		mis_ops = '{OP_LH, OP_LHU, OP_SH, OP_LW, OP_SW};
		rst_n_i = 1'b0;
		req_i = 1'b0;
		op_i = OP_LW;
		addr_i = '0;
		wdata_i = '0;
		cfg_we_i = 1'b0;
		cfg_addr_i = CFG_GUARD_EN;
		cfg_wdata_i = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n_i = 1'b1;

		// Reset values and the guard off at low addresses.
		read_cfg(CFG_GUARD_EN);
		read_cfg(CFG_WP_LIMIT);
		read_cfg(CFG_FAULT_CNT);
		get_rand(r);
		access_mem(OP_SW, 32'h0, r);
		access_mem(OP_SW, 32'h4, ~r);
		access_mem(OP_LW, 32'h0, '0);
		access_mem(OP_LW, 32'h4, '0);
		read_cfg(CFG_GUARD_EN);

		// Random word stores and loads.
		for (int i = 0; i < N_WORDS; i++) begin
			get_rand(r);
			base = r & 32'h0000_0ffc;
			addr_q.push_back(base);
			get_rand(r);
			access_mem(OP_SW, base, r);
			access_mem(OP_LW, base, '0);
		end
		foreach (addr_q[i]) begin
			access_mem(OP_LW, addr_q[i], '0);
		end

		// Byte and halfword lanes.
		for (int w = 0; w < N_LANE_WORDS; w++) begin
			get_rand(r);
			base = r & 32'h0000_0ffc;
			for (int off = 0; off < 4; off++) begin
				get_rand(r);
				access_mem(OP_SW, base, r);
				get_rand(r);
				access_mem(OP_SB, base + off, {r[31:8], off[0] ^ w[0], r[6:0]});
				access_mem(OP_LW, base, '0);
				access_mem(OP_LB, base + off, '0);
				access_mem(OP_LBU, base + off, '0);
			end
			for (int off = 0; off < 4; off += 2) begin
				get_rand(r);
				access_mem(OP_SW, base, r);
				get_rand(r);
				access_mem(OP_SH, base + off, {r[31:16], off[1] ^ w[0], r[14:0]});
				access_mem(OP_LW, base, '0);
				access_mem(OP_LH, base + off, '0);
				access_mem(OP_LHU, base + off, '0);
			end
		end

		// Misaligned requests leave memory alone.
		get_rand(r);
		base = r & 32'h0000_0ffc;
		access_mem(OP_SW, base, r);
		for (int off = 1; off < 4; off++) begin
			foreach (mis_ops[j]) begin
				if (off != 2 || mis_ops[j] == OP_LW || mis_ops[j] == OP_SW) begin
					get_rand(r);
					access_mem(mis_ops[j], base + off, r);
					access_mem(OP_LW, base, '0);
				end
			end
		end

		// Store guard with every target written beforehand.
		addr_q.delete();
		addr_q.push_back(32'h7fc);
		addr_q.push_back(32'h800);
		addr_q.push_back(32'h10);
		for (int i = 0; i < N_GUARD; i++) begin
			get_rand(r);
			addr_q.push_back(r & 32'h0000_0ffc);
		end
		foreach (addr_q[i]) begin
			get_rand(r);
			access_mem(OP_SW, addr_q[i], r);
		end
		write_cfg(CFG_WP_LIMIT, 32'h800);
		write_cfg(CFG_GUARD_EN, 32'h1);
		foreach (addr_q[i]) begin
			get_rand(r);
			access_mem(OP_SW, addr_q[i], r);
		end
		access_mem(OP_SB, 32'h7ff, 32'h5a);
		access_mem(OP_SB, 32'h800, 32'ha5);
		foreach (addr_q[i]) begin
			access_mem(OP_LW, addr_q[i], '0);
		end
		read_cfg(CFG_FAULT_CNT);
		write_cfg(CFG_FAULT_CNT, '0);
		read_cfg(CFG_FAULT_CNT);
		access_mem(OP_SW, 32'h10, 32'h1);
		// Clear and a blocked store in the same cycle.
		drive_cycle(1'b1, OP_SW, 32'h10, 32'h2, 1'b1, CFG_FAULT_CNT, '0);
		read_cfg(CFG_FAULT_CNT);
		read_cfg(CFG_WP_LIMIT);

		drive_cycle(1'b0, OP_LW, '0, '0, 1'b0, CFG_GUARD_EN, '0);
		repeat (2) @(posedge clk);
		$display("All checks passed");
		$finish;
	end

endmodule

/* rtl/mem_stage_top.sv */
module mem_stage_top import mem_pkg::*; #(
	parameter int ADDR_WORDS = 1024
) (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      req_i,
	input  mem_op_e   op_i,
	input  word_t     addr_i,
	input  word_t     wdata_i,
	output word_t     load_data_o,
	output logic      misalign_o,
	output logic      fault_o,
	input  logic      cfg_we_i,
	input  cfg_addr_e cfg_addr_i,
	input  word_t     cfg_wdata_i,
	output word_t     cfg_rdata_o
);

	logic  guard_en;
	word_t wp_limit;

	mem_bus_if u_bus (
		.clk(clk)
	);

	lsu_align u_lsu (
		.req_i      (req_i),
		.op_i       (op_i),
		.addr_i     (addr_i),
		.wdata_i    (wdata_i),
		.guard_en_i (guard_en),
		.wp_limit_i (wp_limit),
		.load_data_o(load_data_o),
		.misalign_o (misalign_o),
		.fault_o    (fault_o),
		.bus        (u_bus.lsu)
	);

	data_ram #(
		.ADDR_WORDS(ADDR_WORDS)
	) u_ram (
		.clk(clk),
		.bus(u_bus.ram)
	);

	// Blocked stores feed the fault counter.
	mem_cfg_regs u_cfg (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.cfg_we_i   (cfg_we_i),
		.cfg_addr_i (cfg_addr_i),
		.cfg_wdata_i(cfg_wdata_i),
		.cfg_rdata_o(cfg_rdata_o),
		.guard_en_o (guard_en),
		.wp_limit_o (wp_limit),
		.fault_i    (fault_o)
	);

endmodule

/* rtl/mem_cfg_regs.sv */
module mem_cfg_regs import mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      cfg_we_i,
	input  cfg_addr_e cfg_addr_i,
	input  word_t     cfg_wdata_i,
	output word_t     cfg_rdata_o,
	output logic      guard_en_o,
	output word_t     wp_limit_o,
	input  logic      fault_i
);

	localparam logic [FAULT_CNT_W-1:0] CNT_MAX = '1;

	logic                   guard_en_q;
	word_t                  wp_limit_q;
	logic [FAULT_CNT_W-1:0] fault_cnt_q;
	logic                   cnt_clr;

	assign cnt_clr = cfg_we_i && (cfg_addr_i == CFG_FAULT_CNT);

	// ####################
	// Registers.
	// ####################

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			guard_en_q  <= 1'b0;
			wp_limit_q  <= '0;
			fault_cnt_q <= '0;
		end else begin
			if (cfg_we_i && cfg_addr_i == CFG_GUARD_EN) begin
				guard_en_q <= cfg_wdata_i[0];
			end
			if (cfg_we_i && cfg_addr_i == CFG_WP_LIMIT) begin
				wp_limit_q <= cfg_wdata_i;
			end
			// Clear beats a same-cycle fault.
			if (cnt_clr) begin
				fault_cnt_q <= '0;
			end else if (fault_i && fault_cnt_q != CNT_MAX) begin
				fault_cnt_q <= fault_cnt_q + 1'b1;
			end
		end
	end

	assign guard_en_o = guard_en_q;
	assign wp_limit_o = wp_limit_q;

	always_comb begin
		case (cfg_addr_i)
			CFG_GUARD_EN:  cfg_rdata_o = {31'b0, guard_en_q};
			CFG_WP_LIMIT:  cfg_rdata_o = wp_limit_q;
			CFG_FAULT_CNT: cfg_rdata_o = word_t'(fault_cnt_q);
			default:       cfg_rdata_o = '0;
		endcase
	end

	a_cnt_mono: assert property (@(posedge clk) disable iff (!rst_n_i)
		!cnt_clr |=> fault_cnt_q >= $past(fault_cnt_q));

endmodule

/* rtl/data_ram.sv */
module data_ram import mem_pkg::*; #(
	parameter int ADDR_WORDS = 1024
) (
	input logic    clk,
	mem_bus_if.ram bus
);

	localparam int IDX_W = $clog2(ADDR_WORDS);

	logic [IDX_W-1:0] idx;
	word_t            rd_word;

	// Word index from the byte address.
	assign idx = bus.addr[IDX_W+1:2];

	// ####################
	// Byte lanes.
	// ####################

	for (genvar lane = 0; lane < 4; lane++) begin : g_lane
		logic [7:0] lane_mem [ADDR_WORDS];

		always_ff @(posedge clk) begin
			if (bus.ce && bus.we && bus.sel[lane]) begin
				lane_mem[idx] <= bus.wdata[8*lane +: 8];
			end
		end

		assign rd_word[8*lane +: 8] = lane_mem[idx];
	end

	// ####################
	// Read port.
	// ####################

	// Only a load drives the read data.
	assign bus.rdata = (bus.ce && !bus.we) ? rd_word : '0;

	a_write_sel: assert property (@(posedge clk) bus.ce && bus.we |-> bus.sel != '0);

endmodule

/* rtl/lsu_align.sv */
module lsu_align import mem_pkg::*; (
	input  logic    req_i,
	input  mem_op_e op_i,
	input  word_t   addr_i,
	input  word_t   wdata_i,
	input  logic    guard_en_i,
	input  word_t   wp_limit_i,
	output word_t   load_data_o,
	output logic    misalign_o,
	output logic    fault_o,
	mem_bus_if.lsu  bus
);

	localparam logic [1:0] SZ_BYTE = 2'd0;
	localparam logic [1:0] SZ_HALF = 2'd1;
	localparam logic [1:0] SZ_WORD = 2'd2;

	logic       is_load;
	logic       is_store;
	logic       sign_ext;
	logic [1:0] size;
	logic       access;
	word_t      rd_shifted;

	// ####################
	// Operation decode.
	// ####################

	always_comb begin
		is_load  = 1'b0;
		is_store = 1'b0;
		sign_ext = 1'b0;
		size     = SZ_WORD;
		case (op_i)
			OP_LB: begin
				is_load  = 1'b1;
				sign_ext = 1'b1;
				size     = SZ_BYTE;
			end
			OP_LBU: begin
				is_load = 1'b1;
				size    = SZ_BYTE;
			end
			OP_LH: begin
				is_load  = 1'b1;
				sign_ext = 1'b1;
				size     = SZ_HALF;
			end
			OP_LHU: begin
				is_load = 1'b1;
				size    = SZ_HALF;
			end
			OP_LW: is_load = 1'b1;
			OP_SB: begin
				is_store = 1'b1;
				size     = SZ_BYTE;
			end
			OP_SH: begin
				is_store = 1'b1;
				size     = SZ_HALF;
			end
			OP_SW: is_store = 1'b1;
			default: ;
		endcase
	end

	// Misalignment wins over the store guard.
	assign misalign_o = req_i && (is_load || is_store) &&
		((size == SZ_HALF && addr_i[0]) || (size == SZ_WORD && addr_i[1:0] != 2'b00));
	assign fault_o = req_i && is_store && !misalign_o && guard_en_i && (addr_i < wp_limit_i);
	assign access = req_i && (is_load || is_store) && !misalign_o && !fault_o;

	// ####################
	// Lane alignment.
	// ####################

	always_comb begin
		case (size)
			SZ_BYTE: bus.sel = 4'b0001 << addr_i[1:0];
			SZ_HALF: bus.sel = 4'b0011 << addr_i[1:0];
			default: bus.sel = 4'b1111;
		endcase
		if (!access) begin
			bus.sel = '0;
		end
	end

	assign bus.ce    = access;
	assign bus.we    = access && is_store;
	assign bus.addr  = addr_i;
	assign bus.wdata = wdata_i << {addr_i[1:0], 3'b000};

	// Addressed byte or halfword moves down to bit 0.
	assign rd_shifted = bus.rdata >> {addr_i[1:0], 3'b000};

	always_comb begin
		case (size)
			SZ_BYTE: load_data_o = {{24{sign_ext & rd_shifted[7]}}, rd_shifted[7:0]};
			SZ_HALF: load_data_o = {{16{sign_ext & rd_shifted[15]}}, rd_shifted[15:0]};
			default: load_data_o = rd_shifted;
		endcase
		if (!(access && is_load)) begin
			load_data_o = '0;
		end
	end

	a_sel_legal: assert property (@(posedge bus.clk)
		bus.ce |-> bus.sel inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
			4'b0011, 4'b1100, 4'b1111});

endmodule

/* rtl/mem_bus_if.sv */
interface mem_bus_if import mem_pkg::*; (
	input logic clk
);

	logic      ce;
	logic      we;
	byte_sel_t sel;
	word_t     addr;
	// Store data, already on its lanes.
	word_t     wdata;
	word_t     rdata;

	modport lsu (input clk, input rdata, output ce, output we, output sel, output addr,
		output wdata);

	modport ram (input ce, input we, input sel, input addr, input wdata, output rdata);

endinterface

/* rtl/mem_pkg.sv */
package mem_pkg;

	// ####################
	// Data types.
	// ####################

	typedef logic [31:0] word_t;

	// One write enable per byte lane, lane 0 is bits 7..0.
	typedef logic [3:0] byte_sel_t;

	// Bit 3 marks a store, bit 2 an unsigned load, bits 1..0 the size.
	typedef enum logic [3:0] {
		OP_LB  = 4'b0000,
		OP_LH  = 4'b0001,
		OP_LW  = 4'b0010,
		OP_LBU = 4'b0100,
		OP_LHU = 4'b0101,
		OP_SB  = 4'b1000,
		OP_SH  = 4'b1001,
		OP_SW  = 4'b1010
	} mem_op_e;

	// ####################
	// Configuration map.
	// ####################

	typedef enum logic [1:0] {
		CFG_GUARD_EN  = 2'd0,
		CFG_WP_LIMIT  = 2'd1,
		CFG_FAULT_CNT = 2'd2
	} cfg_addr_e;

	localparam int FAULT_CNT_W = 8;

endpackage
